/* verif/lsu_golden.txt */
// kind_size_unsign_base_offset_data_expect_exc, kind 0 load 1 store 2 drain 3 DCCM check
// size 0 byte 1 half 2 word, exc 0 none 1 misaligned 2 access fault
1_2_0_f0040100_000_11223344_00000000_0
0_2_0_f0040100_000_00000000_11223344_0
2_0_0_00000000_000_00000000_00000000_0
0_2_0_f0040100_000_00000000_11223344_0
1_2_0_f0040200_000_aabbccdd_00000000_0
1_0_0_f0040200_001_00000095_00000000_0
1_1_0_f0040210_ff2_0000f234_00000000_0
0_2_0_f0040200_000_00000000_f23495dd_0
0_0_0_f0040200_001_00000000_ffffff95_0
0_0_1_f0040200_001_00000000_00000095_0
0_1_0_f0040200_002_00000000_fffff234_0
0_1_1_f0040200_002_00000000_0000f234_0
2_0_0_00000000_000_00000000_00000000_0
0_2_0_f0040200_000_00000000_f23495dd_0
1_2_0_f0040100_002_deadbeef_00000000_1
0_1_0_f0040100_001_00000000_00000000_1
0_2_0_f0050000_000_00000000_00000000_2
1_2_0_f0050000_002_deadbeef_00000000_1
1_0_0_f003ffff_000_000000ee_00000000_2
0_2_0_f0040100_000_00000000_11223344_0
1_2_0_f0040300_000_0a0b0c01_00000000_0
1_2_0_f0040304_000_0a0b0c02_00000000_0
1_2_0_f0040308_000_0a0b0c03_00000000_0
1_2_0_f004030c_000_0a0b0c04_00000000_0
1_2_0_f0040310_000_0a0b0c05_00000000_0
2_0_0_00000000_000_00000000_00000000_0
3_0_0_f0040300_000_00000000_0a0b0c01_0
3_0_0_f004030c_000_00000000_0a0b0c04_0
3_0_0_f0040310_000_00000000_0a0b0c05_0

/* lsu_top.f */
rtl/lsu_pipe_pkg.sv
rtl/lsu_dccm_pkg.sv
rtl/lsu_addr_ctl.sv
rtl/lsu_stbuf_alloc.sv
rtl/lsu_stbuf_entry.sv
rtl/lsu_stbuf_drain.sv
rtl/lsu_dccm_ctl.sv
rtl/lsu_top.sv
verif/lsu_tb.sv

/* verif/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb import lsu_pipe_pkg::*, lsu_dccm_pkg::*; ();

   localparam logic [31:0] DCCM_BASE = 32'hF004_0000;
   localparam int          DCCM_BITS = 16;
   localparam int          SB_DEPTH  = 4;
   localparam int          MAX_RECS  = 64;
   localparam int          RESET_CYC = 3;

   logic                 clk;
   logic                 reset;
   lsu_pkt_t             lsu_p;
   logic [31:0]          rs1_d;
   logic [31:0]          rs2_d;
   logic [11:0]          offset_d;
   logic [31:0]          dccm_rd_data;
   logic [31:0]          lsu_result_m;
   logic                 lsu_result_valid_m;
   lsu_error_pkt_t       lsu_error_pkt_m;
   logic                 lsu_store_stall_any;
   logic                 lsu_idle_any;
   logic                 dccm_rden;
   logic [DCCM_BITS-3:0] dccm_rd_addr;
   dccm_wr_t             dccm_wr;

   logic [31:0]  dccm_mem [0:2**(DCCM_BITS-2)-1];  // Behavioral DCCM
   logic [123:0] recs [0:MAX_RECS-1];              // Golden records
   int           nrec;
   int           cycle_cnt;
   int           cycle_limit;
   int           err_cnt;
   int           test_cnt;
   int           fail_cnt;
   logic         stall_seen;

   // Op waiting in M for its check
   logic         pend_valid;
   logic [3:0]   pend_kind;
   logic [31:0]  pend_exp;
   logic [3:0]   pend_exc;
   logic [31:0]  pend_addr;
   int           pend_idx;

   lsu_top #(
      .DCCM_BASE(DCCM_BASE), .DCCM_BITS(DCCM_BITS), .SB_DEPTH(SB_DEPTH)
   ) dut0 (
      .clk, .reset, .lsu_p, .rs1_d, .rs2_d, .offset_d, .dccm_rd_data,
      .lsu_result_m, .lsu_result_valid_m, .lsu_error_pkt_m,
      .lsu_store_stall_any, .lsu_idle_any,
      .dccm_rden, .dccm_rd_addr, .dccm_wr
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                       // 4 ns period
   end

   //************************************************************
   // DCCM model, read data one cycle after rden
   //************************************************************

   always @(posedge clk) begin
      if (dccm_rden) begin
         dccm_rd_data <= dccm_mem[dccm_rd_addr];
      end
      if (dccm_wr.wren) begin
         for (int b = 0; b < BYTE_LANES; b++) begin
            if (dccm_wr.byteen[b]) begin
               dccm_mem[dccm_wr.addr[DCCM_BITS-3:0]][8*b +: 8] <= dccm_wr.data[8*b +: 8];
            end
         end
      end
   end

   // Run limit from the record count
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   task automatic compare(input string name, input logic [31:0] act, input logic [31:0] exp);
      if (act !== exp) begin
         $display("ERROR at %0t ns: %s got %h expected %h", $time, name, act, exp);
         err_cnt++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      test_cnt++;
      if (err_cnt != errs_before) begin
         fail_cnt++;
         $display("test %0d %s: failed", test_cnt, name);
      end else begin
         $display("test %0d %s: passed", test_cnt, name);
      end
   endtask

   task automatic drive_idle();
      lsu_p    = '0;
      rs1_d    = '0;
      rs2_d    = '0;
      offset_d = '0;
   endtask

   // Check the op that sits in M at this falling edge
   task automatic check_m_stage();
      int errs;
      if (pend_valid) begin
         errs = err_cnt;
         if (pend_exc != 4'd0) begin
            compare("exc_valid", 32'(lsu_error_pkt_m.exc_valid), 32'd1);
            compare("exc_type", 32'(lsu_error_pkt_m.exc_type),
                    (pend_exc == 4'd1) ? 32'd0 : 32'd1);
            compare("exc_addr", lsu_error_pkt_m.addr, pend_addr);
            compare("result_valid", 32'(lsu_result_valid_m), 32'd0);
         end else begin
            compare("exc_valid", 32'(lsu_error_pkt_m.exc_valid), 32'd0);
            if (pend_kind == 4'd0) begin
               compare("result_valid", 32'(lsu_result_valid_m), 32'd1);
               compare("lsu_result_m", lsu_result_m, pend_exp);
            end else begin
               compare("result_valid", 32'(lsu_result_valid_m), 32'd0);
            end
         end
         report_test($sformatf("record %0d %s", pend_idx,
                     (pend_kind == 4'd0) ? "load" : "store"), errs);
         pend_valid = 1'b0;
      end
   endtask

   task automatic next_cycle();
      @(negedge clk);
      check_m_stage();
      if (lsu_store_stall_any) begin
         stall_seen = 1'b1;                        // Buffer close to full
      end
   endtask

   initial begin : main
      logic [123:0] rec;
      logic [3:0]   kind;
      logic [31:0]  base;
      logic [11:0]  off;
      int           errs;
      reset = 1'b1;
      drive_idle();
      dccm_rd_data = '0;
      cycle_cnt    = 0;
      cycle_limit  = 0;
      err_cnt      = 0;
      test_cnt     = 0;
      fail_cnt     = 0;
      stall_seen   = 1'b0;
      pend_valid   = 1'b0;
      for (int i = 0; i < 2**(DCCM_BITS-2); i++) begin
         dccm_mem[i] = {i[15:0], ~i[15:0]} ^ 32'h5a5a_0000;  // Unique per word
      end
      for (int i = 0; i < MAX_RECS; i++) begin
         recs[i] = '1;                             // Kind f ends the list
      end
      $readmemh("verif/lsu_golden.txt", recs);
      nrec = 0;
      while (nrec < MAX_RECS && recs[nrec][123:120] != 4'hf) begin
         nrec++;
      end
      if (nrec == 0) begin
         $display("The golden file holds no records");
         err_cnt++;
      end
      cycle_limit = nrec * 4 + SB_DEPTH * 4 + RESET_CYC;

      repeat (RESET_CYC) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      errs = err_cnt;
      compare("lsu_idle_any", 32'(lsu_idle_any), 32'd1);
      compare("lsu_store_stall_any", 32'(lsu_store_stall_any), 32'd0);
      compare("dccm_rden", 32'(dccm_rden), 32'd0);
      compare("dccm_wr.wren", 32'(dccm_wr.wren), 32'd0);
      compare("result_valid", 32'(lsu_result_valid_m), 32'd0);
      compare("exc_valid", 32'(lsu_error_pkt_m.exc_valid), 32'd0);
      report_test("reset", errs);

      for (int r = 0; r < nrec; r++) begin
         rec  = recs[r];
         kind = rec[123:120];
         base = rec[111:80];
         off  = rec[79:68];
         if (kind <= 4'd1) begin
            while (kind == 4'd1 && lsu_store_stall_any) begin
               stall_seen = 1'b1;                  // Hold the store back
               drive_idle();
               next_cycle();
            end
            lsu_p.valid  = 1'b1;
            lsu_p.load   = (kind == 4'd0);
            lsu_p.store  = (kind == 4'd1);
            lsu_p.unsign = rec[112];
            lsu_p.size   = lsu_size_t'(rec[117:116]);
            rs1_d        = base;
            rs2_d        = rec[67:36];
            offset_d     = off;
            pend_valid   = 1'b1;
            pend_kind    = kind;
            pend_exp     = rec[35:4];
            pend_exc     = rec[3:0];
            pend_addr    = base + {{20{off[11]}}, off};
            pend_idx     = r;
            next_cycle();
            drive_idle();
         end else if (kind == 4'd2) begin
            errs = err_cnt;
            drive_idle();
            next_cycle();
            while (!lsu_idle_any) begin            // Idle cycles let the buffer drain
               next_cycle();
            end
            // Empty buffer, so no stall and no write left
            compare("lsu_store_stall_any", 32'(lsu_store_stall_any), 32'd0);
            compare("dccm_wr.wren", 32'(dccm_wr.wren), 32'd0);
            report_test($sformatf("record %0d drain", r), errs);
         end else begin
            errs = err_cnt;
            compare($sformatf("dccm_mem[%h]", base), dccm_mem[base[DCCM_BITS-1:2]],
                    rec[35:4]);
            report_test($sformatf("record %0d dccm check", r), errs);
         end
      end
      next_cycle();

      if (!stall_seen) begin
         $display("The store stall never went high during the run");
         err_cnt++;
      end
      $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* rtl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top import lsu_pipe_pkg::*, lsu_dccm_pkg::*; #(
   parameter logic [31:0] DCCM_BASE = 32'hF004_0000,
   parameter int          DCCM_BITS = 16,
   parameter int          SB_DEPTH  = 4,
   parameter int          SB_PTR_W  = $clog2(SB_DEPTH)
) (
   input  logic                 clk,
   input  logic                 reset,
   input  lsu_pkt_t             lsu_p,
   input  logic [31:0]          rs1_d,
   input  logic [31:0]          rs2_d,
   input  logic [11:0]          offset_d,
   input  logic [31:0]          dccm_rd_data,
   output logic [31:0]          lsu_result_m,
   output logic                 lsu_result_valid_m,
   output lsu_error_pkt_t       lsu_error_pkt_m,
   output logic                 lsu_store_stall_any,
   output logic                 lsu_idle_any,
   output logic                 dccm_rden,
   output logic [DCCM_BITS-3:0] dccm_rd_addr,      // Word index
   output dccm_wr_t             dccm_wr
);

   logic [31:0]         addr_d;
   logic                rd_req_d;
   lsu_pkt_t            pkt_m;
   logic [31:0]         addr_m;
   logic                stb_wr_m;
   logic [31:0]         stb_data_m;
   lsu_byteen_t         stb_byteen_m;
   logic [SB_DEPTH-1:0] wr_sel;
   logic [SB_DEPTH-1:0] free_sel;
   logic                sb_empty;
   logic                drain_done;
   logic                drain_ok;
   stbuf_entry_t        entries [SB_DEPTH];
   stbuf_fwd_t          fwds [SB_DEPTH];
   stbuf_fwd_t          fwd_m;

   lsu_addr_ctl #(.DCCM_BASE(DCCM_BASE), .DCCM_BITS(DCCM_BITS)) u_addr_ctl (
      .clk, .reset, .lsu_p, .rs1_d, .rs2_d, .offset_d,
      .addr_d, .rd_req_d, .pkt_m, .addr_m,
      .stb_wr_m, .stb_data_m, .stb_byteen_m, .lsu_error_pkt_m
   );

   lsu_stbuf_alloc #(.SB_DEPTH(SB_DEPTH), .SB_PTR_W(SB_PTR_W)) u_alloc (
      .clk, .reset, .stb_wr_m, .drain_done,
      .wr_sel, .sb_empty, .lsu_store_stall_any
   );

   // Store buffer slots
   for (genvar i = 0; i < SB_DEPTH; i++) begin : g_entry
      lsu_stbuf_entry u_entry (
         .clk, .reset,
         .wr_en      (wr_sel[i]),
         .wr_addr    (addr_m[31:2]),
         .wr_data    (stb_data_m),
         .wr_byteen  (stb_byteen_m),
         .free_en    (free_sel[i]),
         .ld_addr_m  (addr_m[31:2]),
         .ld_valid_m (pkt_m.valid & pkt_m.load),
         .entry      (entries[i]),
         .fwd        (fwds[i])
      );
   end

   lsu_stbuf_drain #(.SB_DEPTH(SB_DEPTH), .SB_PTR_W(SB_PTR_W)) u_drain (
      .clk, .reset, .entries, .fwds, .drain_ok,
      .dccm_wr, .free_sel, .drain_done, .fwd_m
   );

   lsu_dccm_ctl #(.DCCM_BITS(DCCM_BITS)) u_dccm_ctl (
      .clk, .reset, .rd_req_d,
      .addr_d   (addr_d[DCCM_BITS-1:2]),
      .pkt_m,
      .addr_m   (addr_m[1:0]),
      .fwd_m, .dccm_rd_data,
      .dccm_rden, .dccm_rd_addr, .drain_ok,
      .lsu_result_m, .lsu_result_valid_m
   );

   // Nothing buffered and nothing in M
   assign lsu_idle_any = sb_empty & ~pkt_m.valid;

endmodule

/* rtl/lsu_dccm_ctl.sv */
`timescale 1ns/1ps

module lsu_dccm_ctl import lsu_pipe_pkg::*, lsu_dccm_pkg::*; #(
   parameter int DCCM_BITS = 16
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 rd_req_d,        // Clean load in D
   input  logic [DCCM_BITS-1:2] addr_d,          // Word index in the DCCM
   input  lsu_pkt_t             pkt_m,
   input  logic [1:0]           addr_m,          // Byte offset of the load in M
   input  stbuf_fwd_t           fwd_m,
   input  logic [31:0]          dccm_rd_data,
   output logic                 dccm_rden,
   output logic [DCCM_BITS-3:0] dccm_rd_addr,
   output logic                 drain_ok,
   output logic [31:0]          lsu_result_m,
   output logic                 lsu_result_valid_m
);

   logic        rd_req_m;
   logic [31:0] merged_m;                        // Read data with forwarded bytes
   logic [31:0] shifted_m;

   //**********************************************************
   // Port sharing, loads first
   //**********************************************************

   assign dccm_rden    = rd_req_d;
   assign dccm_rd_addr = addr_d;
   assign drain_ok     = ~rd_req_d;              // Store drains on any free cycle

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_req_m <= 1'b0;
      end else begin
         rd_req_m <= rd_req_d;
      end
   end

   //**********************************************************
   // M stage load data
   //**********************************************************

   always_comb begin
      for (int b = 0; b < BYTE_LANES; b++) begin
         merged_m[8*b +: 8] = fwd_m.hit[b] ? fwd_m.data[8*b +: 8]
                                           : dccm_rd_data[8*b +: 8];
      end
   end

   assign shifted_m = merged_m >> {addr_m, 3'b000};  // Access to bit 0

   always_comb begin
      case (pkt_m.size)
         SZ_BYTE: lsu_result_m = {{24{~pkt_m.unsign & shifted_m[7]}}, shifted_m[7:0]};
         SZ_HALF: lsu_result_m = {{16{~pkt_m.unsign & shifted_m[15]}}, shifted_m[15:0]};
         default: lsu_result_m = shifted_m;
      endcase
   end

   assign lsu_result_valid_m = rd_req_m;

   // Result strobe only for a load carried into M
   a_result_is_load: assert property (@(posedge clk) disable iff (reset)
      lsu_result_valid_m |-> (pkt_m.valid && pkt_m.load));

endmodule

/* rtl/lsu_stbuf_drain.sv */
`timescale 1ns/1ps

module lsu_stbuf_drain import lsu_dccm_pkg::*; #(
   parameter int SB_DEPTH = 4,
   parameter int SB_PTR_W = 2
) (
   input  logic                clk,
   input  logic                reset,
   input  stbuf_entry_t        entries [SB_DEPTH],
   input  stbuf_fwd_t          fwds [SB_DEPTH],
   input  logic                drain_ok,        // DCCM port free this cycle
   output dccm_wr_t            dccm_wr,
   output logic [SB_DEPTH-1:0] free_sel,
   output logic                drain_done,
   output stbuf_fwd_t          fwd_m            // Merged forward for the load in M
);

   logic [SB_PTR_W-1:0] rd_ptr;                 // Oldest entry
   stbuf_entry_t        oldest;

   //**********************************************************
   // Drain of the oldest entry
   //**********************************************************

   assign oldest = entries[rd_ptr];

   assign dccm_wr.wren   = drain_ok & oldest.valid;
   assign dccm_wr.addr   = oldest.addr;
   assign dccm_wr.byteen = oldest.byteen;
   assign dccm_wr.data   = oldest.data;

   assign drain_done = dccm_wr.wren;

   always_comb begin
      for (int i = 0; i < SB_DEPTH; i++) begin
         free_sel[i] = drain_done && (rd_ptr == SB_PTR_W'(i));
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_ptr <= '0;
      end else if (drain_done) begin
         rd_ptr <= (rd_ptr == SB_PTR_W'(SB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
   end

   //**********************************************************
   // Forward merge, youngest hit wins per byte
   //**********************************************************

   always_comb begin : fwd_merge
      int idx;
      fwd_m = '0;
      // Oldest to newest, so a younger hit overwrites an older one
      for (int i = 0; i < SB_DEPTH; i++) begin
         idx = int'(rd_ptr) + i;
         if (idx >= SB_DEPTH) begin
            idx = idx - SB_DEPTH;          // Wrap around the ring
         end
         for (int b = 0; b < BYTE_LANES; b++) begin
            if (fwds[idx].hit[b]) begin
               fwd_m.hit[b]         = 1'b1;
               fwd_m.data[8*b +: 8] = fwds[idx].data[8*b +: 8];
            end
         end
      end
   end

   // A drained slot is empty afterwards, so no slot goes to DCCM twice
   a_drain_frees: assert property (@(posedge clk) disable iff (reset)
      dccm_wr.wren |=> !entries[$past(rd_ptr)].valid);

endmodule

/* rtl/lsu_stbuf_entry.sv */
`timescale 1ns/1ps

module lsu_stbuf_entry import lsu_dccm_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  logic         wr_en,             // From alloc
   input  logic [29:0]  wr_addr,
   input  logic [31:0]  wr_data,
   input  lsu_byteen_t  wr_byteen,
   input  logic         free_en,           // From drain
   input  logic [29:0]  ld_addr_m,         // Word address of the load in M
   input  logic         ld_valid_m,
   output stbuf_entry_t entry,
   output stbuf_fwd_t   fwd
);

   logic        valid;
   logic [29:0] addr;
   lsu_byteen_t byteen;
   logic [31:0] data;
   logic        match;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid <= 1'b0;
      end else if (wr_en) begin
         valid <= 1'b1;
      end else if (free_en) begin
         valid <= 1'b0;                    // Drained to DCCM
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         addr   <= wr_addr;
         byteen <= wr_byteen;
         data   <= wr_data;
      end
   end

   assign entry = '{valid: valid, addr: addr, byteen: byteen, data: data};

   // Word compare, then the covered bytes
   assign match    = ld_valid_m & valid & (addr == ld_addr_m);
   assign fwd.hit  = match ? byteen : '0;
   assign fwd.data = data;

   // Alloc and drain never pick the same slot
   a_wr_free_excl: assert property (@(posedge clk) disable iff (reset)
      !(wr_en && free_en));

endmodule

/* rtl/lsu_stbuf_alloc.sv */
`timescale 1ns/1ps

module lsu_stbuf_alloc #(
   parameter int SB_DEPTH = 4,
   parameter int SB_PTR_W = 2
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                stb_wr_m,        // Store leaves M this cycle
   input  logic                drain_done,      // One entry written to DCCM
   output logic [SB_DEPTH-1:0] wr_sel,          // Entry to load at end of M
   output logic                sb_empty,
   output logic                lsu_store_stall_any
);

   logic [SB_PTR_W-1:0] wr_ptr;
   logic [SB_PTR_W:0]   count;                  // Occupied entries

   // Decode the write pointer, one hot
   always_comb begin
      for (int i = 0; i < SB_DEPTH; i++) begin
         wr_sel[i] = stb_wr_m && (wr_ptr == SB_PTR_W'(i));
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (stb_wr_m) begin
            wr_ptr <= (wr_ptr == SB_PTR_W'(SB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         case ({stb_wr_m, drain_done})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;        // None or both, no change
         endcase
      end
   end

   assign sb_empty = (count == '0);

   // Stall with two or fewer free, covers the stores still in D and M
   assign lsu_store_stall_any = (count >= (SB_PTR_W + 1)'(SB_DEPTH - 2));

   // Environment must honor the stall
   a_no_write_full: assert property (@(posedge clk) disable iff (reset)
      (count == (SB_PTR_W + 1)'(SB_DEPTH)) |-> !stb_wr_m);

endmodule

/* rtl/lsu_addr_ctl.sv */
`timescale 1ns/1ps

module lsu_addr_ctl import lsu_pipe_pkg::*, lsu_dccm_pkg::*; #(
   parameter logic [31:0] DCCM_BASE = 32'hF004_0000,
   parameter int          DCCM_BITS = 16
) (
   input  logic           clk,
   input  logic           reset,
   input  lsu_pkt_t       lsu_p,            // Control packet in D
   input  logic [31:0]    rs1_d,            // Base operand
   input  logic [31:0]    rs2_d,            // Store data
   input  logic [11:0]    offset_d,         // Signed offset
   output logic [31:0]    addr_d,
   output logic           rd_req_d,         // Clean load, may read the DCCM
   output lsu_pkt_t       pkt_m,
   output logic [31:0]    addr_m,
   output logic           stb_wr_m,         // Clean store reaches the buffer
   output logic [31:0]    stb_data_m,       // Store data on its byte lanes
   output lsu_byteen_t    stb_byteen_m,
   output lsu_error_pkt_t lsu_error_pkt_m
);

   logic [31:0] end_addr_d;                 // Last byte touched
   logic [1:0]  last_off_d;                 // Size in bytes minus one
   logic        misaligned_d;
   logic        in_dccm_d;
   logic        access_d;
   logic        exc_d;
   logic        st_req_d;
   lsu_byteen_t byteen_d;
   logic        exc_valid_m;
   lsu_exc_t    exc_type_m;

   //**********************************************************
   // D stage, address and checks
   //**********************************************************

   assign addr_d = rs1_d + {{20{offset_d[11]}}, offset_d};

   always_comb begin
      case (lsu_p.size)
         SZ_BYTE: begin
            last_off_d   = 2'd0;
            misaligned_d = 1'b0;
            byteen_d     = 4'b0001 << addr_d[1:0];
         end
         SZ_HALF: begin
            last_off_d   = 2'd1;
            misaligned_d = addr_d[0];
            byteen_d     = 4'b0011 << addr_d[1:0];
         end
         default: begin                     // Word
            last_off_d   = 2'd3;
            misaligned_d = |addr_d[1:0];
            byteen_d     = 4'b1111;
         end
      endcase
   end

   assign end_addr_d = addr_d + {30'b0, last_off_d};

   // Both ends must fall in the window
   assign in_dccm_d = (addr_d[31:DCCM_BITS] == DCCM_BASE[31:DCCM_BITS]) &&
                      (end_addr_d[31:DCCM_BITS] == DCCM_BASE[31:DCCM_BITS]);

   assign access_d = lsu_p.valid & (lsu_p.load | lsu_p.store);
   assign exc_d    = access_d & (misaligned_d | ~in_dccm_d);
   assign rd_req_d = access_d & lsu_p.load & ~exc_d;
   assign st_req_d = access_d & lsu_p.store & ~exc_d;   // A fault never enters the buffer

   //**********************************************************
   // D to M register
   //**********************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         pkt_m       <= '0;
         stb_wr_m    <= 1'b0;
         exc_valid_m <= 1'b0;
      end else begin
         pkt_m       <= lsu_p;
         stb_wr_m    <= st_req_d;
         exc_valid_m <= exc_d;
      end
   end

   always_ff @(posedge clk) begin
      addr_m       <= addr_d;
      stb_data_m   <= rs2_d << {addr_d[1:0], 3'b000};  // Move to byte lanes
      stb_byteen_m <= byteen_d;
      exc_type_m   <= misaligned_d ? EXC_MISALIGNED : EXC_ACCESS_FAULT;  // Misalign wins
   end

   assign lsu_error_pkt_m = '{exc_valid: exc_valid_m, exc_type: exc_type_m, addr: addr_m};

   // A clean read lies inside the window and on its size boundary
   a_rd_no_fault: assert property (@(posedge clk) disable iff (reset)
      rd_req_d |-> ({1'b0, addr_d} >= {1'b0, DCCM_BASE}) &&
                   ({1'b0, end_addr_d} < ({1'b0, DCCM_BASE} + (33'd1 << DCCM_BITS))) &&
                   ((addr_d[1:0] & last_off_d) == 2'b00));

endmodule

/* rtl/lsu_dccm_pkg.sv */
package lsu_dccm_pkg;

   localparam int BYTE_LANES = 4;      // Bytes per DCCM word

   typedef logic [BYTE_LANES-1:0] lsu_byteen_t;

   //**********************************************************
   // Store buffer and DCCM port types
   //**********************************************************

   // One buffered store, word granular
   typedef struct packed {
      logic        valid;
      logic [29:0] addr;               // Word address, byte addr[31:2]
      lsu_byteen_t byteen;             // Bytes this store covers
      logic [31:0] data;               // Already placed on its byte lanes
   } stbuf_entry_t;                    // 67 bits

   // Bytes a load in M can take from the buffer
   typedef struct packed {
      lsu_byteen_t hit;                // One bit per byte lane
      logic [31:0] data;
   } stbuf_fwd_t;                      // 36 bits

   // Write request to the single DCCM port
   typedef struct packed {
      logic        wren;
      logic [29:0] addr;               // Word address, low bits index the array
      lsu_byteen_t byteen;
      logic [31:0] data;
   } dccm_wr_t;                        // 67 bits

endpackage

/* rtl/lsu_pipe_pkg.sv */
package lsu_pipe_pkg;

   //**********************************************************
   // Access size and control packet of the load/store pipe
   //**********************************************************

   typedef enum logic [1:0] {
      SZ_BYTE = 2'b00,                 // 8 bit access
      SZ_HALF = 2'b01,                 // 16 bit, needs addr[0] clear
      SZ_WORD = 2'b10                  // 32 bit, needs addr[1:0] clear
   } lsu_size_t;

   // Control packet as issued in D and carried to M
   typedef struct packed {
      logic      valid;                // Packet is live
      logic      load;
      logic      store;
      logic      unsign;               // Zero extend the load result
      lsu_size_t size;
   } lsu_pkt_t;                        // 6 bits

   //**********************************************************
   // Error reporting
   //**********************************************************

   typedef enum logic {
      EXC_MISALIGNED   = 1'b0,         // Address not aligned to size
      EXC_ACCESS_FAULT = 1'b1          // Access leaves the DCCM window
   } lsu_exc_t;

   // Exception packet, valid in M
   typedef struct packed {
      logic        exc_valid;
      lsu_exc_t    exc_type;
      logic [31:0] addr;               // Faulting byte address
   } lsu_error_pkt_t;                  // 34 bits

endpackage
